// File: include/bp_settings.svh
// Branch predictor sizes
// Table geometry, address field positions and counter widths shared by
// every block of the predictor
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

//////////////////////////////////////////////////
// Table geometry
//////////////////////////////////////////////////
`define BP_SETS              512
`define BP_INDEX_WIDTH       9
`define BP_COUNTERS_PER_SET  4
`define BP_COUNTER_WIDTH     2
`define BP_MISS_COUNT_WIDTH  32

// Global history, same length as the set index for the gshare XOR
`define BP_HISTORY_WIDTH     9

//////////////////////////////////////////////////
// Fetch address fields
//////////////////////////////////////////////////
`define BP_PC_WIDTH          32
`define BP_SELECT_LSB        2   // PC[3:2] picks a counter in the set
`define BP_SELECT_WIDTH      2
`define BP_INDEX_LSB         4   // PC[12:4] feeds the set hash

`endif

// File: hw/bp_addr_pkg.sv
// Address-side types of the branch predictor
// Fetch PC, hashed set index, counter select and global history

`include "bp_settings.svh"

package bp_addr_pkg;

    // Fetch address as seen by front end and back end
    typedef logic [`BP_PC_WIDTH-1:0] pc_t;

    // One of the table sets, after the history hash
    typedef logic [`BP_INDEX_WIDTH-1:0] set_index_t;

    // Which counter inside a set
    typedef logic [`BP_SELECT_WIDTH-1:0] counter_sel_t;

    // Resolved outcomes, newest in bit 0
    typedef logic [`BP_HISTORY_WIDTH-1:0] history_t;

endpackage

// File: hw/bp_table_pkg.sv
// Table-side types of the branch predictor
// Saturating counter, packed set of counters and the miss tally

`include "bp_settings.svh"

package bp_table_pkg;

    // One 2-bit saturating counter, upper bit gives the direction
    typedef logic [`BP_COUNTER_WIDTH-1:0] counter_t;

    // All counters of one set, counter 0 in the low bits
    typedef logic [`BP_COUNTERS_PER_SET*`BP_COUNTER_WIDTH-1:0] set_counters_t;

    // Lookups that landed on an invalid set
    typedef logic [`BP_MISS_COUNT_WIDTH-1:0] miss_count_t;

endpackage

// File: hw/bht_update_if.sv
// Table write bus
// Carries one write command per cycle from the index decoder to the
// branch history table

`timescale 1ns/100ps

interface bht_update_if;

    logic                      write_enable;   // One-cycle strobe
    bp_addr_pkg::set_index_t   write_index;
    bp_addr_pkg::counter_sel_t write_select;
    logic                      write_inc;      // At most one of inc/dec is high
    logic                      write_dec;
    logic                      write_valid;    // New valid bit of the set

    // Decoder drives the command
    modport decode (
        output write_enable,
        output write_index,
        output write_select,
        output write_inc,
        output write_dec,
        output write_valid
    );

    // Table side
    modport tbl (
        input write_enable,
        input write_index,
        input write_select,
        input write_inc,
        input write_dec,
        input write_valid
    );

endinterface

// File: hw/branch_index_decode.sv
// Branch index decoder
// Keeps the global history register and hashes lookup, update and
// invalidate PCs into set indices. Builds one table read and one
// prioritised table write per cycle, update over invalidate.

`timescale 1ns/100ps
`include "bp_settings.svh"

module branch_index_decode (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      lookup_valid,
    input  bp_addr_pkg::pc_t          lookup_pc,
    input  logic                      update_valid,
    input  bp_addr_pkg::pc_t          update_pc,
    input  logic                      update_taken,
    input  logic                      invalidate_valid,
    input  bp_addr_pkg::pc_t          invalidate_pc,
    output logic                      read_enable,
    output bp_addr_pkg::set_index_t   read_index,
    output bp_addr_pkg::counter_sel_t read_select,
    bht_update_if.decode              wr
);

    bp_addr_pkg::history_t history_q;   // Global outcome history
    bp_addr_pkg::pc_t      write_pc;    // PC of the winning write

    // gshare hash of the PC index field with the current history
    function automatic bp_addr_pkg::set_index_t hash_index(
        input bp_addr_pkg::pc_t      pc,
        input bp_addr_pkg::history_t history
    );
        return pc[`BP_INDEX_LSB +: `BP_INDEX_WIDTH] ^ history;
    endfunction

    function automatic bp_addr_pkg::counter_sel_t counter_select(input bp_addr_pkg::pc_t pc);
        return pc[`BP_SELECT_LSB +: `BP_SELECT_WIDTH];
    endfunction

    //////////////////////////////////////////////////
    // History register
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            history_q <= '0;
        end else if (update_valid) begin
            // Newest outcome enters at bit 0
            history_q <= {history_q[`BP_HISTORY_WIDTH-2:0], update_taken};
        end
    end

    //////////////////////////////////////////////////
    // Read command, uses history before this cycle's update
    //////////////////////////////////////////////////
    assign read_enable = lookup_valid;
    assign read_index  = hash_index(lookup_pc, history_q);
    assign read_select = counter_select(lookup_pc);

    //////////////////////////////////////////////////
    // Write command
    //////////////////////////////////////////////////
    assign write_pc = update_valid ? update_pc : invalidate_pc;   // Update wins

    assign wr.write_enable = update_valid | invalidate_valid;
    assign wr.write_index  = hash_index(write_pc, history_q);
    assign wr.write_select = counter_select(write_pc);
    assign wr.write_inc    = update_valid & update_taken;
    assign wr.write_dec    = update_valid & ~update_taken;
    assign wr.write_valid  = update_valid;   // Invalidate alone clears the set

endmodule

// File: hw/bht.sv
// Branch history table
// 512 sets of four 2-bit saturating counters, each set with a valid bit.
// One counter changes per write. A write to the set being read in the
// same cycle is bypassed into the registered read data, while the valid
// flag read out is the stored one. Lookups of invalid sets are counted.

`timescale 1ns/100ps
`include "bp_settings.svh"

module bht (
    input  logic                        clock,
    input  logic                        reset_n,
    bht_update_if.tbl                   wr,
    input  logic                        read_enable,
    input  bp_addr_pkg::set_index_t     read_index,
    output bp_table_pkg::set_counters_t read_data,
    output logic                        read_valid,
    output bp_table_pkg::miss_count_t   miss_count
);

    bp_table_pkg::set_counters_t counters [`BP_SETS];   // Counter storage
    logic [`BP_SETS-1:0]         valid_bits;

    bp_table_pkg::set_counters_t write_set;   // Set contents after the write
    logic                        bypass;      // Read and write hit the same set

    // Saturating step of one counter
    function automatic bp_table_pkg::counter_t saturate(
        input bp_table_pkg::counter_t value,
        input logic                   inc,
        input logic                   dec
    );
        bp_table_pkg::counter_t result;
        result = value;
        if (inc && (value != '1)) begin
            result = value + bp_table_pkg::counter_t'(1);
        end else if (dec && (value != '0)) begin
            result = value - bp_table_pkg::counter_t'(1);
        end
        return result;
    endfunction

    // Apply the step to the selected counter, others pass unchanged
    function automatic bp_table_pkg::set_counters_t update_set(
        input bp_table_pkg::set_counters_t set_in,
        input bp_addr_pkg::counter_sel_t   sel,
        input logic                        inc,
        input logic                        dec
    );
        bp_table_pkg::set_counters_t set_out;
        set_out = set_in;
        set_out[sel*`BP_COUNTER_WIDTH +: `BP_COUNTER_WIDTH] =
            saturate(set_in[sel*`BP_COUNTER_WIDTH +: `BP_COUNTER_WIDTH], inc, dec);
        return set_out;
    endfunction

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////
    assign write_set = update_set(counters[wr.write_index], wr.write_select,
                                  wr.write_inc, wr.write_dec);

    assign bypass = wr.write_enable && (wr.write_index == read_index);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            counters   <= '{default: '0};
            valid_bits <= '0;
        end else if (wr.write_enable) begin
            counters[wr.write_index]   <= write_set;   // Unchanged on invalidate
            valid_bits[wr.write_index] <= wr.write_valid;
        end
    end

    //////////////////////////////////////////////////
    // Read path, outputs hold when idle
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data  <= '0;
            read_valid <= 1'b0;
            miss_count <= '0;
        end else if (read_enable) begin
            if (bypass) begin
                read_data <= write_set;
            end else begin
                read_data <= counters[read_index];
            end
            read_valid <= valid_bits[read_index];   // Pre-write valid bit

            // Lookup of an invalid set
            if (!valid_bits[read_index]) begin
                miss_count <= miss_count + bp_table_pkg::miss_count_t'(1);
            end
        end
    end

endmodule

// File: hw/prediction_select.sv
// Prediction select
// Delays the lookup strobe and counter select to line up with the table
// read, then picks the chosen counter and forms hit and direction

`timescale 1ns/100ps
`include "bp_settings.svh"

module prediction_select (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        read_enable,
    input  bp_addr_pkg::counter_sel_t   read_select,
    input  bp_table_pkg::set_counters_t read_data,
    input  logic                        read_valid,
    output logic                        predict_valid,
    output logic                        predict_hit,
    output logic                        predict_taken
);

    bp_addr_pkg::counter_sel_t select_q;   // Counter choice of the pending lookup
    bp_table_pkg::counter_t    chosen;

    // Strobe, cleared at reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            predict_valid <= 1'b0;
        end else begin
            predict_valid <= read_enable;
        end
    end

    // Select follows each lookup
    always_ff @(posedge clock) begin
        if (read_enable) begin
            select_q <= read_select;
        end
    end

    //////////////////////////////////////////////////
    // Direction from the counter's upper bit
    //////////////////////////////////////////////////
    assign chosen = read_data[select_q*`BP_COUNTER_WIDTH +: `BP_COUNTER_WIDTH];

    assign predict_hit   = read_valid;
    assign predict_taken = read_valid & chosen[`BP_COUNTER_WIDTH-1];   // Miss predicts not taken

endmodule

// File: hw/branch_predictor.sv
// Branch direction predictor
// gshare-indexed branch history table. A lookup returns a prediction
// and hit flag one cycle later; resolved branches train the counters
// and an invalidate clears the valid bit of one set.

`timescale 1ns/100ps

module branch_predictor (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      lookup_valid,
    input  bp_addr_pkg::pc_t          lookup_pc,
    input  logic                      update_valid,
    input  bp_addr_pkg::pc_t          update_pc,
    input  logic                      update_taken,
    input  logic                      invalidate_valid,
    input  bp_addr_pkg::pc_t          invalidate_pc,
    output logic                      predict_valid,
    output logic                      predict_hit,
    output logic                      predict_taken,
    output bp_table_pkg::miss_count_t miss_count
);

    // Read command from the decoder
    logic                        read_enable;
    bp_addr_pkg::set_index_t     read_index;
    bp_addr_pkg::counter_sel_t   read_select;

    // Table read result
    bp_table_pkg::set_counters_t read_data;
    logic                        read_valid;

    bht_update_if wr_bus ();   // Table write command

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////
    branch_index_decode i_decode (
        .clock            (clock),
        .reset_n          (reset_n),
        .lookup_valid     (lookup_valid),
        .lookup_pc        (lookup_pc),
        .update_valid     (update_valid),
        .update_pc        (update_pc),
        .update_taken     (update_taken),
        .invalidate_valid (invalidate_valid),
        .invalidate_pc    (invalidate_pc),
        .read_enable      (read_enable),
        .read_index       (read_index),
        .read_select      (read_select),
        .wr               (wr_bus.decode)
    );

    bht i_bht (
        .clock       (clock),
        .reset_n     (reset_n),
        .wr          (wr_bus.tbl),
        .read_enable (read_enable),
        .read_index  (read_index),
        .read_data   (read_data),
        .read_valid  (read_valid),
        .miss_count  (miss_count)
    );

    prediction_select i_select (
        .clock         (clock),
        .reset_n       (reset_n),
        .read_enable   (read_enable),
        .read_select   (read_select),
        .read_data     (read_data),
        .read_valid    (read_valid),
        .predict_valid (predict_valid),
        .predict_hit   (predict_hit),
        .predict_taken (predict_taken)
    );

endmodule

// File: bench/branch_predictor_properties.sv
// Branch predictor properties
// Lookup to prediction latency, hit and direction consistency, miss
// counter growth and the prediction strobe during reset

`timescale 1ns/100ps

module branch_predictor_properties (
    input logic                      clock,
    input logic                      reset_n,
    input logic                      lookup_valid,
    input logic                      predict_valid,
    input logic                      predict_hit,
    input logic                      predict_taken,
    input bp_table_pkg::miss_count_t miss_count
);

    //////////////////////////////////////////////////
    // Strobe timing
    //////////////////////////////////////////////////
    latency_after_lookup: assert property (
        @(posedge clock) disable iff (!reset_n) lookup_valid |=> predict_valid
    ) else $error("predict_valid missing one cycle after a lookup");

    latency_no_lookup: assert property (
        @(posedge clock) disable iff (!reset_n) !lookup_valid |=> !predict_valid
    ) else $error("predict_valid high without a lookup one cycle earlier");

    // A miss never predicts taken
    taken_needs_hit: assert property (
        @(posedge clock) disable iff (!reset_n) !predict_hit |-> !predict_taken
    ) else $error("predict_taken high while predict_hit is low");

    miss_count_grows: assert property (
        @(posedge clock) disable iff (!reset_n) miss_count >= $past(miss_count)
    ) else $error("miss_count decreased");

    //////////////////////////////////////////////////
    // Reset state
    //////////////////////////////////////////////////
    quiet_in_reset: assert property (
        @(posedge clock) !reset_n |-> !predict_valid
    ) else $error("predict_valid high during reset");

endmodule

bind branch_predictor branch_predictor_properties i_properties (
    .clock         (clock),
    .reset_n       (reset_n),
    .lookup_valid  (lookup_valid),
    .predict_valid (predict_valid),
    .predict_hit   (predict_hit),
    .predict_taken (predict_taken),
    .miss_count    (miss_count)
);

// File: bench/branch_predictor_tb.sv
// Branch predictor testbench
// Directed and random lookups, updates and invalidates against a reference
// model of the gshare table; assertions compare hit, direction and miss count

`timescale 1ns/100ps
`include "bp_settings.svh"

module branch_predictor_tb;

    localparam int RANDOM_CYCLES      = 2800;
    localparam int DIRECTED_ALLOWANCE = 200;
    localparam int CYCLE_LIMIT        = 2 * (RANDOM_CYCLES + DIRECTED_ALLOWANCE);

    logic                      clock;
    logic                      reset_n;
    logic                      lookup_valid;
    bp_addr_pkg::pc_t          lookup_pc;
    logic                      update_valid;
    bp_addr_pkg::pc_t          update_pc;
    logic                      update_taken;
    logic                      invalidate_valid;
    bp_addr_pkg::pc_t          invalidate_pc;
    logic                      predict_valid;
    logic                      predict_hit;
    logic                      predict_taken;
    bp_table_pkg::miss_count_t miss_count;

    // Reference model
    bp_table_pkg::counter_t    model_counters [`BP_SETS][`BP_COUNTERS_PER_SET];
    logic [`BP_SETS-1:0]       model_valid;
    bp_addr_pkg::history_t     model_history;
    bp_table_pkg::miss_count_t model_misses;

    // Expected result of the lookup in flight
    logic                      exp_hit;
    logic                      exp_taken;
    bp_table_pkg::miss_count_t exp_misses;

    int          errors          = 0;
    int          errors_at_start = 0;
    int          checks          = 0;
    int          cycles          = 0;
    int          test_number     = 1;

    branch_predictor i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Model and checks
    //////////////////////////////////////////////////
    task automatic clear_model();
        for (int s = 0; s < `BP_SETS; s++) begin
            for (int c = 0; c < `BP_COUNTERS_PER_SET; c++) begin
                model_counters[s][c] = 2'd0;
            end
        end
        model_valid   = '0;
        model_history = '0;
        model_misses  = '0;
    endtask

    always @(posedge clock) begin : model_step
        bp_addr_pkg::set_index_t   look_set;
        bp_addr_pkg::set_index_t   write_set;
        bp_addr_pkg::counter_sel_t write_sel;
        bp_addr_pkg::pc_t          write_pc;
        logic                      stored_valid;
        if (!reset_n) begin
            clear_model();
        end else begin
            write_pc     = update_valid ? update_pc : invalidate_pc;   // Update wins
            look_set     = lookup_pc[`BP_INDEX_LSB +: `BP_INDEX_WIDTH] ^ model_history;
            write_set    = write_pc[`BP_INDEX_LSB +: `BP_INDEX_WIDTH] ^ model_history;
            write_sel    = write_pc[`BP_SELECT_LSB +: `BP_SELECT_WIDTH];
            stored_valid = model_valid[look_set];   // Valid before this cycle's write
            if (update_valid) begin
                if (update_taken && model_counters[write_set][write_sel] != 2'd3) begin
                    model_counters[write_set][write_sel] += 2'd1;
                end else if (!update_taken && model_counters[write_set][write_sel] != 2'd0) begin
                    model_counters[write_set][write_sel] -= 2'd1;
                end
                model_valid[write_set] = 1'b1;
                model_history = {model_history[`BP_HISTORY_WIDTH-2:0], update_taken};
            end else if (invalidate_valid) begin
                model_valid[write_set] = 1'b0;
            end
            if (lookup_valid) begin
                if (!stored_valid) begin
                    model_misses = model_misses + 32'd1;
                end
                exp_hit    = stored_valid;
                exp_taken  = stored_valid &
                    model_counters[look_set][lookup_pc[`BP_SELECT_LSB +: `BP_SELECT_WIDTH]][1];
                exp_misses = model_misses;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
        errors++;
    endtask

    // Compare outputs half a cycle after the rising edge
    always @(negedge clock) begin
        if (reset_n && predict_valid) begin
            checks++;
            assert (predict_hit === exp_hit)
                else report_mismatch("predict_hit", 32'(exp_hit), 32'(predict_hit));
            assert (predict_taken === exp_taken)
                else report_mismatch("predict_taken", 32'(exp_taken), 32'(predict_taken));
            assert (miss_count === exp_misses)
                else report_mismatch("miss_count", exp_misses, miss_count);
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    // PC that hashes to a given set under the current history
    function automatic bp_addr_pkg::pc_t pc_for_set(input bp_addr_pkg::set_index_t target,
                                                    input bp_addr_pkg::counter_sel_t sel);
        bp_addr_pkg::pc_t pc;
        pc = 32'h8000_0000;
        pc[`BP_INDEX_LSB +: `BP_INDEX_WIDTH]   = target ^ model_history;
        pc[`BP_SELECT_LSB +: `BP_SELECT_WIDTH] = sel;
        return pc;
    endfunction

    function automatic bp_addr_pkg::pc_t pool_pc(input int unsigned slot);
        return 32'h0000_2000 + 32'(slot) * 32'h0000_0134;
    endfunction

    // Inputs change right after a falling edge and hold for one cycle
    task automatic drive_cycle(input logic lv, input bp_addr_pkg::pc_t lpc, input logic uv,
                               input bp_addr_pkg::pc_t upc, input logic taken,
                               input logic iv, input bp_addr_pkg::pc_t ipc);
        lookup_valid     = lv;
        lookup_pc        = lpc;
        update_valid     = uv;
        update_pc        = upc;
        update_taken     = taken;
        invalidate_valid = iv;
        invalidate_pc    = ipc;
        @(negedge clock);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic do_lookup(input int target, input int sel);
        drive_cycle(1'b1, pc_for_set(9'(target), 2'(sel)), 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic train(input int target, input int sel, input logic taken, input int times);
        repeat (times) begin
            drive_cycle(1'b0, '0, 1'b1, pc_for_set(9'(target), 2'(sel)), taken, 1'b0, '0);
        end
    endtask

    task automatic end_test(input string name);
        idle_cycle();
        idle_cycle();
        $display("Test %0d %s done, %0d mismatches", test_number, name, errors - errors_at_start);
        test_number++;
        errors_at_start = errors;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h70536030));
        reset_n = 1'b0;
        lookup_valid = 1'b0;
        lookup_pc = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_taken = 1'b0;
        invalidate_valid = 1'b0;
        invalidate_pc = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        for (int s = 0; s < 6; s++) do_lookup(s * 71, s % 4);   // All sets start invalid
        end_test("reset_misses");

        train(37, 1, 1'b1, 5);   // Saturates at 3
        do_lookup(37, 1);
        train(37, 1, 1'b0, 2);
        do_lookup(37, 1);
        train(37, 1, 1'b0, 3);   // Holds at 0
        do_lookup(37, 1);
        end_test("saturation");

        train(100, 2, 1'b1, 3);
        for (int c = 0; c < 4; c++) do_lookup(100, c);
        end_test("counter_isolation");

        train(37, 1, 1'b1, 1);
        drive_cycle(1'b1, pc_for_set(9'd37, 2'd1), 1'b1, pc_for_set(9'd37, 2'd1), 1'b1,
                    1'b0, '0);
        drive_cycle(1'b1, pc_for_set(9'd200, 2'd0), 1'b1, pc_for_set(9'd200, 2'd0), 1'b1,
                    1'b0, '0);
        do_lookup(200, 0);
        end_test("write_bypass");

        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b1, pc_for_set(9'd37, 2'd1));
        do_lookup(37, 1);
        train(37, 1, 1'b1, 1);
        do_lookup(37, 1);
        drive_cycle(1'b0, '0, 1'b1, pc_for_set(9'd37, 2'd1), 1'b0, 1'b1,
                    pc_for_set(9'd37, 2'd1));
        do_lookup(37, 1);
        end_test("invalidate");

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            drive_cycle(($urandom % 10) < 6, pool_pc($urandom % 8), ($urandom % 10) < 4,
                        pool_pc($urandom % 8), ($urandom % 2) == 1, ($urandom % 10) < 1,
                        pool_pc($urandom % 8));
        end
        end_test("random_mix");

        $display("Checks %0d, mismatches %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: branch_predictor.f
+incdir+include
hw/bp_addr_pkg.sv
hw/bp_table_pkg.sv
hw/bht_update_if.sv
hw/branch_index_decode.sv
hw/bht.sv
hw/prediction_select.sv
hw/branch_predictor.sv
bench/branch_predictor_properties.sv
bench/branch_predictor_tb.sv

// File: Makefile
# Verilator build and run of the branch predictor testbench

TOP = branch_predictor_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f branch_predictor.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
